//--- mem_hierarchy.f
source/mem_geom_pkg.sv
source/mem_ctrl_pkg.sv
source/cache_array.sv
source/cache_controller.sv
source/unified_mem.sv
source/mem_hierarchy.sv
test/mem_hierarchy_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory hierarchy testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=mem_hierarchy_tb
build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
	--top-module "$top" --Mdir "$build_dir" \
	-f mem_hierarchy.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
	exit 1
fi

if ! grep -q "Simulation finished: PASS" "$log"; then
	echo "No pass line found in $log"
	exit 1
fi

exit 0

//--- test/mem_hierarchy_tb.sv
`timescale 1ns/1ns

module mem_hierarchy_tb import mem_geom_pkg::*;;

	localparam int RANDOM_OPS = 300;
	localparam int DIRECTED_REQUESTS = 13;
	localparam int TIMEOUT_CYCLES = (RANDOM_OPS + DIRECTED_REQUESTS) * 200 + 100;

	localparam logic [ADDR_W-1:0] FETCH_ADDR = 16'h3a05;
	localparam logic [ADDR_W-1:0] LINE_BASE  = 16'h1234;
	// Same index 4, tags 0x55 and 0x66
	localparam logic [ADDR_W-1:0] ADDR_A = 16'h5510;
	localparam logic [ADDR_W-1:0] ADDR_B = 16'h6610;
	localparam logic [WORD_W-1:0] VAL_A = 16'hbeef;
	localparam logic [WORD_W-1:0] VAL_B = 16'h0c1d;

	logic              clk;
	logic              i_reset;
	logic [ADDR_W-1:0] i_i_addr;
	logic [ADDR_W-1:0] i_d_addr;
	logic [WORD_W-1:0] i_d_wdata;
	logic              i_d_re;
	logic              i_d_we;
	logic [WORD_W-1:0] o_instr;
	logic              o_i_rdy;
	logic [WORD_W-1:0] o_d_rdata;
	logic              o_d_rdy;

	// Word view of memory as the data port should see it
	logic [WORD_W-1:0] shadow [65536];

	int seed;
	int errors;
	int checks;
	int tests;
	int test_errors_start;
	int cycle_count;

	mem_hierarchy mem_hierarchy_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_i_addr(i_i_addr),
		.i_d_addr(i_d_addr),
		.i_d_wdata(i_d_wdata),
		.i_d_re(i_d_re),
		.i_d_we(i_d_we),
		.o_instr(o_instr),
		.o_i_rdy(o_i_rdy),
		.o_d_rdata(o_d_rdata),
		.o_d_rdy(o_d_rdy)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	assert property (@(posedge clk) disable iff (i_reset) o_d_rdy |-> (i_d_re || i_d_we))
	else begin
		$display("Data ready was high with no data request pending");
		errors++;
	end

	// A held fetch address keeps hitting
	assert property (@(posedge clk) disable iff (i_reset)
		($past(o_i_rdy) && $stable(i_i_addr)) |-> o_i_rdy)
	else begin
		$display("Instruction hit was lost while the fetch address was held");
		errors++;
	end

	task automatic check_word(input string name, input logic [WORD_W-1:0] expected,
		input logic [WORD_W-1:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// Sampled just after the falling edge, well clear of the rising edge
	task automatic wait_fetch();
		#1;
		while (!o_i_rdy) begin
			@(negedge clk);
			#1;
		end
	endtask

	task automatic wait_data();
		#1;
		while (!o_d_rdy) begin
			@(negedge clk);
			#1;
		end
	endtask

	task automatic fetch(input string name, input logic [ADDR_W-1:0] addr,
		input logic [WORD_W-1:0] expected);
		@(negedge clk);
		i_i_addr = addr;
		wait_fetch();
		check_word(name, expected, o_instr);
	endtask

	task automatic data_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		@(negedge clk);
		i_d_addr  = addr;
		i_d_wdata = data;
		i_d_we    = 1'b1;
		wait_data();
		shadow[addr] = data;
		@(negedge clk);
		i_d_we = 1'b0;
	endtask

	task automatic data_read(input string name, input logic [ADDR_W-1:0] addr);
		@(negedge clk);
		i_d_addr = addr;
		i_d_re   = 1'b1;
		wait_data();
		check_word(name, shadow[addr], o_d_rdata);
		@(negedge clk);
		i_d_re = 1'b0;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %s finished with %0d failures", name, errors - test_errors_start);
		test_errors_start = errors;
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, a ready output never arrived", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [ADDR_W-1:0] addr;
		seed = 59888;
		errors = 0;
		checks = 0;
		tests = 0;
		test_errors_start = 0;
		for (int i = 0; i < 65536; i++) begin
			shadow[i] = '0;
		end
		i_reset   = 1'b1;
		i_i_addr  = FETCH_ADDR;
		i_d_addr  = '0;
		i_d_wdata = '0;
		i_d_re    = 1'b0;
		i_d_we    = 1'b0;
		repeat (4) @(negedge clk);
		i_reset = 1'b0;

		// Cold fetch reads zero memory, then a same-line fetch hits at once
		#1;
		check_word("reset_fetch", 16'd0, 16'(o_d_rdy));
		wait_fetch();
		check_word("reset_fetch", 16'd0, o_instr);
		@(negedge clk);
		i_i_addr = FETCH_ADDR + 16'd1;
		#1;
		check_word("reset_fetch", 16'd1, 16'(o_i_rdy));
		check_word("reset_fetch", 16'd0, o_instr);
		end_test("reset_fetch");

		data_write(LINE_BASE + 16'd2, 16'ha5c3);
		for (int k = 0; k < 4; k++) begin
			data_read("line_write", LINE_BASE + 16'(k));
		end
		end_test("line_write");

		// B evicts dirty A, then A evicts dirty B
		data_write(ADDR_A, VAL_A);
		data_write(ADDR_B, VAL_B);
		data_read("writeback", ADDR_A);
		end_test("writeback");

		fetch("fetch_evicted", ADDR_A, VAL_A);
		end_test("fetch_evicted");

		// Instruction miss is served before the data miss
		@(negedge clk);
		i_i_addr = ADDR_B;
		i_d_addr = ADDR_B;
		i_d_re   = 1'b1;
		wait_fetch();
		check_word("fetch_and_miss", VAL_B, o_instr);
		wait_data();
		check_word("fetch_and_miss", shadow[ADDR_B], o_d_rdata);
		@(negedge clk);
		i_d_re = 1'b0;
		end_test("fetch_and_miss");

		// Tags 0x70 to 0x73, indices 8 to 11
		for (int n = 0; n < RANDOM_OPS; n++) begin
			r = $random(seed);
			addr = {6'b011100, r[1:0], 4'b0010, r[3:2], r[5:4]};
			if (r[6]) begin
				data_write(addr, r[31:16]);
			end else begin
				data_read("random", addr);
			end
		end
		end_test("random");

		$display("tests %0d, checks %0d, failures %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- source/mem_hierarchy.sv
`timescale 1ns/1ns

module mem_hierarchy import mem_geom_pkg::*; (
	input  logic              clk,
	input  logic              i_reset,
	input  logic [ADDR_W-1:0] i_i_addr,
	input  logic [ADDR_W-1:0] i_d_addr,
	input  logic [WORD_W-1:0] i_d_wdata,
	input  logic              i_d_re,
	input  logic              i_d_we,
	output logic [WORD_W-1:0] o_instr,
	output logic              o_i_rdy,
	output logic [WORD_W-1:0] o_d_rdata,
	output logic              o_d_rdy
);

	logic [LINE_ADDR_W-1:0] i_line_addr;
	logic [LINE_ADDR_W-1:0] d_line_addr;
	logic [LINE_ADDR_W-1:0] victim_addr;
	logic [LINE_ADDR_W-1:0] mem_addr;
	logic [OFFSET_W-1:0]    i_offset;
	logic [OFFSET_W-1:0]    d_offset;
	logic [LINE_W-1:0]      icache_line;
	logic [LINE_W-1:0]      dcache_line;
	logic [LINE_W-1:0]      merged_line;
	logic [LINE_W-1:0]      dcache_wline;
	logic [LINE_W-1:0]      mem_rdata;
	logic [TAG_W-1:0]       dcache_tag;
	logic icache_hit;
	logic dcache_hit;
	logic dcache_dirty;
	logic icache_we;
	logic dcache_we;
	logic d_set_dirty;
	logic d_refill_sel;
	logic mem_sel_d;
	logic evict;
	logic mem_cyc;
	logic mem_stb;
	logic mem_we;
	logic mem_ack;

	assign i_line_addr = i_i_addr[ADDR_W-1:OFFSET_W];
	assign d_line_addr = i_d_addr[ADDR_W-1:OFFSET_W];
	assign i_offset    = i_i_addr[OFFSET_W-1:0];
	assign d_offset    = i_d_addr[OFFSET_W-1:0];

	// Word select
	assign o_instr   = icache_line[i_offset*WORD_W +: WORD_W];
	assign o_d_rdata = dcache_line[d_offset*WORD_W +: WORD_W];

	assign o_i_rdy = icache_hit;
	// A write completes on the edge that stores it
	assign o_d_rdy = dcache_hit && (i_d_re || (i_d_we && dcache_we));

	always_comb begin
		merged_line = dcache_line;
		merged_line[d_offset*WORD_W +: WORD_W] = i_d_wdata;
	end

	assign dcache_wline = d_refill_sel ? mem_rdata : merged_line;

	// Victim lives at the stored tag with the same index
	assign victim_addr = {dcache_tag, d_line_addr[INDEX_W-1:0]};
	assign mem_addr    = !mem_sel_d ? i_line_addr : (evict ? victim_addr : d_line_addr);

	cache_array icache_inst (
		.clk(clk), .i_reset(i_reset), .i_addr(i_line_addr), .i_wdata(mem_rdata),
		.i_we(icache_we), .i_wdirty(1'b0),
		.o_rdata(icache_line), .o_tag(), .o_hit(icache_hit), .o_dirty()
	);

	cache_array dcache_inst (
		.clk(clk), .i_reset(i_reset), .i_addr(d_line_addr), .i_wdata(dcache_wline),
		.i_we(dcache_we), .i_wdirty(d_set_dirty),
		.o_rdata(dcache_line), .o_tag(dcache_tag), .o_hit(dcache_hit), .o_dirty(dcache_dirty)
	);

	cache_controller cache_controller_inst (
		.clk(clk), .i_reset(i_reset), .i_i_hit(icache_hit), .i_d_hit(dcache_hit),
		.i_d_dirty(dcache_dirty), .i_d_re(i_d_re), .i_d_we(i_d_we), .i_ack(mem_ack),
		.o_cyc(mem_cyc), .o_stb(mem_stb), .o_we(mem_we),
		.o_i_we(icache_we), .o_d_we(dcache_we), .o_d_set_dirty(d_set_dirty),
		.o_d_refill_sel(d_refill_sel), .o_mem_sel_d(mem_sel_d), .o_evict(evict)
	);

	unified_mem unified_mem_inst (
		.clk(clk), .i_reset(i_reset), .i_cyc(mem_cyc), .i_stb(mem_stb), .i_we(mem_we),
		.i_addr(mem_addr), .i_wdata(dcache_line),
		.o_rdata(mem_rdata), .o_ack(mem_ack)
	);

endmodule

//--- source/unified_mem.sv
`timescale 1ns/1ns

module unified_mem import mem_geom_pkg::*, mem_ctrl_pkg::*; (
	input  logic                   clk,
	input  logic                   i_reset,
	input  logic                   i_cyc,
	input  logic                   i_stb,
	input  logic                   i_we,
	input  logic [LINE_ADDR_W-1:0] i_addr,
	input  logic [LINE_W-1:0]      i_wdata,
	output logic [LINE_W-1:0]      o_rdata,
	output logic                   o_ack
);

	logic [LINE_W-1:0] mem [2**LINE_ADDR_W];
	logic [$clog2(MEM_LATENCY)-1:0] lat_cnt;
	logic lat_done;

	// Backing store starts cleared
	initial begin
		for (int i = 0; i < 2**LINE_ADDR_W; i++) begin
			mem[i] = '0;
		end
	end

	// Last wait cycle of an open strobe
	assign lat_done = i_cyc && i_stb && !o_ack &&
		(lat_cnt == $bits(lat_cnt)'(MEM_LATENCY - 1));

	always_ff @(posedge clk) begin
		if (i_reset) begin
			lat_cnt <= '0;
			o_ack   <= 1'b0;
		end else if (lat_done) begin
			lat_cnt <= '0;
			o_ack   <= 1'b1;
		end else if (i_cyc && i_stb && !o_ack) begin
			lat_cnt <= lat_cnt + 1'b1;
		end else begin
			lat_cnt <= '0;
			o_ack   <= 1'b0;
		end
	end

	// Access lands on the acknowledge edge, read data is valid with ack
	always_ff @(posedge clk) begin
		if (lat_done) begin
			if (i_we) begin
				mem[i_addr] <= i_wdata;
			end else begin
				o_rdata <= mem[i_addr];
			end
		end
	end

	assert property (@(posedge clk) disable iff (i_reset) i_stb |-> i_cyc)
		else $error("CHECK FAILED unified_mem: stb without cyc");

endmodule

//--- source/cache_controller.sv
`timescale 1ns/1ns

module cache_controller import mem_ctrl_pkg::*; (
	input  logic clk,
	input  logic i_reset,
	input  logic i_i_hit,
	input  logic i_d_hit,
	input  logic i_d_dirty,
	input  logic i_d_re,
	input  logic i_d_we,
	input  logic i_ack,
	output logic o_cyc,
	output logic o_stb,
	output logic o_we,
	output logic o_i_we,
	output logic o_d_we,
	output logic o_d_set_dirty,
	output logic o_d_refill_sel,
	output logic o_mem_sel_d,
	output logic o_evict
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic stb_q;
	logic stb_next;
	logic i_miss;
	logic d_req;
	logic d_miss;

	// Fetch port is always live
	assign i_miss = !i_i_hit;
	assign d_req  = i_d_re || i_d_we;
	assign d_miss = d_req && !i_d_hit;

	always_comb begin
		state_next = state;
		stb_next   = stb_q;
		case (state)
			IDLE: begin
				// Instruction miss wins when both are pending
				if (i_miss) begin
					state_next = I_REFILL;
					stb_next   = 1'b1;
				end else if (d_miss) begin
					state_next = i_d_dirty ? D_WRITEBACK : D_REFILL;
					stb_next   = 1'b1;
				end
			end
			I_REFILL: begin
				if (i_ack) begin
					state_next = IDLE;
					stb_next   = 1'b0;
				end
			end
			D_WRITEBACK: begin
				if (i_ack) begin
					state_next = D_REFILL;
					stb_next   = 1'b0;
				end
			end
			D_REFILL: begin
				if (i_ack) begin
					state_next = D_UPDATE;
					stb_next   = 1'b0;
				end else begin
					// Restart the bus after the idle cycle that follows a writeback
					stb_next = 1'b1;
				end
			end
			D_UPDATE: begin
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
				stb_next   = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= IDLE;
			stb_q <= 1'b0;
		end else begin
			state <= state_next;
			stb_q <= stb_next;
		end
	end

	// Wishbone classic, cyc and stb move together
	assign o_cyc = stb_q;
	assign o_stb = stb_q;
	assign o_we  = (state == D_WRITEBACK);

	// Victim address comes from the stored tag
	assign o_evict     = (state == D_WRITEBACK);
	assign o_mem_sel_d = (state == D_WRITEBACK) || (state == D_REFILL);

	// Refill writes a clean line, a write hit writes the merged line dirty
	assign o_d_refill_sel = (state == D_REFILL);
	assign o_d_set_dirty  = (state != D_REFILL);

	assign o_i_we = (state == I_REFILL) && i_ack;
	assign o_d_we = ((state == D_REFILL) && i_ack) ||
		(((state == IDLE) || (state == D_UPDATE)) && i_d_we && i_d_hit);

	// Master holds the request until the slave answers
	assert property (@(posedge clk) disable iff (i_reset)
		(o_stb && !i_ack) |=> (o_stb && $stable(o_we)))
		else $error("CHECK FAILED cache_controller: request dropped before ack");

	// A bus cycle only starts for a real miss
	assert property (@(posedge clk) disable iff (i_reset)
		((state == IDLE) && !i_miss && !d_miss) |=> !o_stb)
		else $error("CHECK FAILED cache_controller: strobe without a miss");

endmodule

//--- source/cache_array.sv
`timescale 1ns/1ns

module cache_array import mem_geom_pkg::*; (
	input  logic                   clk,
	input  logic                   i_reset,
	input  logic [LINE_ADDR_W-1:0] i_addr,
	input  logic [LINE_W-1:0]      i_wdata,
	input  logic                   i_we,
	input  logic                   i_wdirty,
	output logic [LINE_W-1:0]      o_rdata,
	output logic [TAG_W-1:0]       o_tag,
	output logic                   o_hit,
	output logic                   o_dirty
);

	logic [LINE_W-1:0] data_mem [NUM_SETS];
	logic [TAG_W-1:0]  tag_mem  [NUM_SETS];
	logic [NUM_SETS-1:0] valid_q;
	logic [NUM_SETS-1:0] dirty_q;

	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;

	assign index = i_addr[INDEX_W-1:0];
	assign tag   = i_addr[LINE_ADDR_W-1 -: TAG_W];

	// Combinational lookup of the addressed set
	assign o_rdata = data_mem[index];
	assign o_tag   = tag_mem[index];
	assign o_hit   = valid_q[index] && (tag_mem[index] == tag);
	assign o_dirty = dirty_q[index];

	// Line payload and tag
	always_ff @(posedge clk) begin
		if (i_we) begin
			data_mem[index] <= i_wdata;
			tag_mem[index]  <= tag;
		end
	end

	// Status bits
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (i_we) begin
			valid_q[index] <= 1'b1;
			dirty_q[index] <= i_wdirty;
		end
	end

	// Once reset has cleared the tags the controller must keep the array quiet
	assert property (@(posedge clk) (i_reset && $past(i_reset)) |-> !i_we)
		else $error("CHECK FAILED cache_array: write during reset");

endmodule

//--- source/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

	// Controller states
	//   IDLE         serve hits, watch for misses
	//   I_REFILL     read a line into the instruction cache
	//   D_WRITEBACK  write the dirty victim to memory
	//   D_REFILL     read the missing line into the data cache
	//   D_UPDATE     refilled line now hits, a pending write merges here
	typedef enum logic [2:0] {
		IDLE        = 3'd0,
		I_REFILL    = 3'd1,
		D_WRITEBACK = 3'd2,
		D_REFILL    = 3'd3,
		D_UPDATE    = 3'd4
	} ctrl_state_t;

	// Cycles from strobe rising to acknowledge
	localparam int MEM_LATENCY = 4;

endpackage

//--- source/mem_geom_pkg.sv
package mem_geom_pkg;

	// Processor word address and data word
	localparam int ADDR_W = 16;
	localparam int WORD_W = 16;

	// Word offset within a line
	localparam int OFFSET_W = 2;

	// Four words per line
	localparam int LINE_W = WORD_W << OFFSET_W;

	// Set index bits sit just above the offset
	localparam int INDEX_W = 6;

	// Line address is tag plus index
	localparam int LINE_ADDR_W = ADDR_W - OFFSET_W;

	// Remaining upper bits form the tag
	localparam int TAG_W = LINE_ADDR_W - INDEX_W;

	// Direct mapped, one line per set
	localparam int NUM_SETS = 1 << INDEX_W;

endpackage
